// File: mips_decode.f
+incdir+test
hdl/mips_pkg.sv
hdl/main_decoder.sv
hdl/alu_decoder.sv
hdl/reg_file.sv
hdl/branch_resolver.sv
hdl/decode_stage.sv
test/tb_decode_stage.sv

// File: test/decode_model.svh
// mirror of the register file, r0 never written
logic [31:0] shadow [0:31];

initial begin
	for (int i = 0; i < 32; i++) begin
		shadow[i] = 32'd0;
	end
end

// operand as seen between the edges, writeback of that cycle bypassed
function automatic logic [31:0] shadow_read(input logic [4:0] addr);
	if (addr == 5'd0) begin
		return 32'd0;
	end
	if (wb_en && (wb_addr == addr)) begin
		return wb_data;
	end
	return shadow[addr];
endfunction

// fields in control word order, leftmost first
function automatic logic [0:ctrl_width-1] pack_ctrl(
	input logic rw, input logic [1:0] dst, input logic pc_src, input logic imm_src,
	input logic [1:0] wsrc, input logic hi_rd, input logic hi_wr, input logic br,
	input logic upper, input logic jmp, input logic cp0_wr);
	return {rw, dst, pc_src, imm_src, wsrc, hi_rd, hi_wr, br, upper, jmp, cp0_wr};
endfunction

function automatic logic [0:ctrl_width-1] model_control(input instr_t w);
	case (w.r.op)
		op_r_type: begin
			case (w.r.funct)
				fn_mthi, fn_mtlo: return pack_ctrl(0, 2'b00, 0, 0, 2'b00, 1, 1, 0, 0, 0, 0);
				fn_mfhi, fn_mflo: return pack_ctrl(1, 2'b01, 0, 0, 2'b00, 1, 0, 0, 0, 0, 0);
				fn_mult, fn_multu, fn_div, fn_divu:
					return pack_ctrl(1, 2'b01, 0, 0, 2'b00, 0, 1, 0, 0, 0, 0);
				fn_jr: return pack_ctrl(0, 2'b00, 0, 0, 2'b00, 0, 0, 0, 0, 1, 0);
				// link into rd
				fn_jalr: return pack_ctrl(1, 2'b01, 1, 0, 2'b00, 0, 0, 0, 0, 1, 0);
				default: return pack_ctrl(1, 2'b01, 0, 0, 2'b00, 0, 0, 0, 0, 0, 0);
			endcase
		end
		op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori:
			return pack_ctrl(1, 2'b00, 0, 1, 2'b00, 0, 0, 0, 0, 0, 0);
		op_lui: return pack_ctrl(1, 2'b00, 0, 1, 2'b00, 0, 0, 0, 1, 0, 0);
		op_lw, op_lb, op_lbu, op_lh, op_lhu:
			return pack_ctrl(1, 2'b00, 0, 1, 2'b01, 0, 0, 0, 0, 0, 0);
		op_sw, op_sb, op_sh: return pack_ctrl(0, 2'b00, 0, 1, 2'b00, 0, 0, 0, 0, 0, 0);
		op_beq, op_bne, op_blez, op_bgtz:
			return pack_ctrl(0, 2'b00, 0, 0, 2'b00, 0, 0, 1, 0, 0, 0);
		// and-link forms write r31, any other rt is a plain branch
		op_branchs: begin
			if ((w.r.rt == rt_bltzal) || (w.r.rt == rt_bgezal)) begin
				return pack_ctrl(1, 2'b10, 1, 0, 2'b00, 0, 0, 1, 0, 0, 0);
			end
			return pack_ctrl(0, 2'b00, 0, 0, 2'b00, 0, 0, 1, 0, 0, 0);
		end
		op_j: return pack_ctrl(0, 2'b00, 0, 0, 2'b00, 0, 0, 0, 0, 1, 0);
		op_jal: return pack_ctrl(1, 2'b10, 1, 0, 2'b00, 0, 0, 0, 0, 1, 0);
		op_cop0: begin
			case (w.r.rs)
				rs_mfc: return pack_ctrl(0, 2'b00, 0, 0, 2'b10, 0, 0, 0, 0, 0, 0);
				rs_mtc: return pack_ctrl(0, 2'b00, 0, 0, 2'b00, 0, 0, 0, 0, 0, 1);
				default: return '0;
			endcase
		end
		default: return '0;
	endcase
endfunction

function automatic logic [3:0] model_alu(input instr_t w);
	if (w.r.op == op_r_type) begin
		case (w.r.funct)
			fn_add: return alu_add;
			fn_addu: return alu_addu;
			fn_sub: return alu_sub;
			fn_subu: return alu_subu;
			fn_and: return alu_and;
			fn_or: return alu_or;
			fn_xor: return alu_xor;
			fn_nor: return alu_nor;
			fn_slt: return alu_slt;
			fn_sltu: return alu_sltu;
			fn_sll, fn_sllv: return alu_sll;
			fn_srl, fn_srlv: return alu_srl;
			fn_sra, fn_srav: return alu_sra;
			default: return alu_nop;
		endcase
	end
	case (w.r.op)
		op_addi: return alu_add;
		op_addiu: return alu_addu;
		op_slti: return alu_slt;
		op_sltiu: return alu_sltu;
		op_andi: return alu_and;
		op_ori: return alu_or;
		op_xori: return alu_xor;
		op_lui: return alu_lui;
		// address add for every memory op
		op_lw, op_lb, op_lbu, op_lh, op_lhu, op_sw, op_sb, op_sh: return alu_addu;
		default: return alu_nop;
	endcase
endfunction

function automatic logic [31:0] model_imm(input instr_t w, input logic [0:ctrl_width-1] ctrl);
	logic signed [31:0] sext;
	sext = $signed(w.i.imm);
	if (ctrl[ctl_upper_imm]) begin
		return {w.i.imm, 16'h0000};
	end
	// logical immediates are unsigned
	if ((w.i.op == op_andi) || (w.i.op == op_ori) || (w.i.op == op_xori)) begin
		return {16'h0000, w.i.imm};
	end
	return sext;
endfunction

function automatic logic [4:0] model_dst(input instr_t w, input logic [0:ctrl_width-1] ctrl);
	case (ctrl[ctl_reg_dst +: 2])
		2'b01: return w.r.rd;
		2'b10: return 5'd31;
		default: return w.r.rt;
	endcase
endfunction

function automatic logic model_taken(input instr_t w, input logic [0:ctrl_width-1] ctrl,
	input logic [31:0] rs, input logic [31:0] rt);
	logic cond;
	case (w.r.op)
		op_beq: cond = (rs == rt);
		op_bne: cond = (rs != rt);
		op_blez: cond = ($signed(rs) <= 0);
		op_bgtz: cond = ($signed(rs) > 0);
		op_branchs: begin
			if ((w.r.rt == rt_bltz) || (w.r.rt == rt_bltzal)) begin
				cond = ($signed(rs) < 0);
			end else if ((w.r.rt == rt_bgez) || (w.r.rt == rt_bgezal)) begin
				cond = ($signed(rs) >= 0);
			end else begin
				cond = 1'b0;
			end
		end
		default: cond = 1'b0;
	endcase
	return ctrl[ctl_jump] || (ctrl[ctl_branch] && cond);
endfunction

function automatic logic [31:0] model_target(input instr_t w, input logic [0:ctrl_width-1] ctrl,
	input logic [31:0] pc, input logic [31:0] rs);
	logic signed [31:0] offset;
	offset = $signed(w.i.imm);
	if (ctrl[ctl_jump]) begin
		// register jumps take rs whole
		if ((w.r.op == op_r_type) && ((w.r.funct == fn_jr) || (w.r.funct == fn_jalr))) begin
			return rs;
		end
		return {pc[31:28], w.j.target, 2'b00};
	end
	return pc + (offset <<< 2);
endfunction

// File: test/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
	import mips_pkg::*;

	// instructions over all tests, 32 extra for the register fill
	localparam int total_txn = 32 + 64 + 400 + 150 + 150 + 200 + 200;
	localparam int cycle_limit = total_txn * 4 + 100;

	typedef struct packed {
		instr_t      instr;
		logic [31:0] pc;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
	} txn_t;

	logic                  clk;
	logic                  rst_n;
	logic                  stall;
	logic                  instr_valid;
	instr_t                instr;
	logic [31:0]           pc_plus4;
	logic                  wb_en;
	logic [4:0]            wb_addr;
	logic [31:0]           wb_data;
	logic                  ex_valid;
	logic [0:ctrl_width-1] ex_control;
	logic [3:0]            ex_alu_op;
	logic [31:0]           ex_rs_val;
	logic [31:0]           ex_rt_val;
	logic [31:0]           ex_imm;
	logic [4:0]            ex_dst;
	logic                  ex_branch_taken;
	logic [31:0]           ex_target;

	integer      seed;
	int          pass_count = 0;
	int          fail_count = 0;
	int          edge_no = 0;
	// outputs reloaded at the last edge
	bit          load_pending = 1'b1;
	logic [151:0] out_held;
	txn_t        exp_q [$];
	txn_t        head;
	txn_t        entry;
	// model of the input register
	logic        m_in_valid = 1'b0;
	instr_t      m_in_instr;
	logic [31:0] m_in_pc;

	// legal codes for the weighted pick
	logic [5:0] op_list [0:21] = '{op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz,
		op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui,
		op_lw, op_lb, op_lbu, op_lh, op_lhu, op_sw, op_sb, op_sh};
	logic [5:0] fn_list [0:25] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
		fn_xor, fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
		fn_jr, fn_jalr, fn_mfhi, fn_mflo, fn_mthi, fn_mtlo, fn_mult, fn_multu, fn_div, fn_divu};
	logic [4:0] rt_list [0:3] = '{rt_bltz, rt_bgez, rt_bltzal, rt_bgezal};
	logic [4:0] rs_list [0:1] = '{rs_mfc, rs_mtc};

	`include "decode_model.svh"

	decode_stage UUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.stall           (stall),
		.instr_valid     (instr_valid),
		.instr           (instr),
		.pc_plus4        (pc_plus4),
		.wb_en           (wb_en),
		.wb_addr         (wb_addr),
		.wb_data         (wb_data),
		.ex_valid        (ex_valid),
		.ex_control      (ex_control),
		.ex_alu_op       (ex_alu_op),
		.ex_rs_val       (ex_rs_val),
		.ex_rt_val       (ex_rt_val),
		.ex_imm          (ex_imm),
		.ex_dst          (ex_dst),
		.ex_branch_taken (ex_branch_taken),
		.ex_target       (ex_target)
	);

	always #50 clk = ~clk;

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// zero, one, all ones and the sign edges, plus plain random
	function automatic logic [31:0] pick_value();
		case (pick(6))
			0: return 32'd0;
			1: return 32'd1;
			2: return 32'hffff_ffff;
			3: return 32'h8000_0000;
			4: return 32'h7fff_ffff;
			default: return $random(seed);
		endcase
	endfunction

	// mode 0 mixed, 1 alu, 2 immediate, 3 branch
	function automatic instr_t make_instr(input int mode);
		instr_t w;
		int     cls;
		w = $random(seed);
		cls = pick(100);
		if (mode == 3) begin
			// few registers so operands often match
			w.r.rs = pick(8);
			w.r.rt = pick(8);
			if (cls < 35) begin
				w.r.op = op_list[2 + pick(4)];
			end else if (cls < 60) begin
				w.r.op = op_branchs;
				w.r.rt = rt_list[pick(4)];
			end else if (cls < 75) begin
				w.r.op = op_list[pick(2)];
			end else begin
				w.r.op = op_r_type;
				w.r.funct = (pick(2) == 0) ? fn_jr : fn_jalr;
			end
		end else if (mode == 2) begin
			w.r.op = op_list[6 + pick(16)];
			case (pick(5))
				0: w.i.imm = 16'h0000;
				1: w.i.imm = 16'h7fff;
				2: w.i.imm = 16'h8000;
				3: w.i.imm = 16'hffff;
			endcase
		end else if ((mode == 1) && (cls >= 55)) begin
			w.r.op = op_list[6 + pick(8)];
		end else if ((mode == 1) || ((cls >= 10) && (cls < 40))) begin
			w.r.op = op_r_type;
			w.r.funct = fn_list[pick(26)];
		end else if ((cls >= 40) && (cls < 50)) begin
			w.r.op = op_branchs;
			// odd rt now and then
			if (pick(8) != 0) begin
				w.r.rt = rt_list[pick(4)];
			end
		end else if ((cls >= 50) && (cls < 58)) begin
			w.r.op = op_cop0;
			if (pick(4) != 0) begin
				w.r.rs = rs_list[pick(2)];
			end
		end else if (cls >= 58) begin
			w.r.op = op_list[pick(22)];
		end
		// below 10 the raw word stays, mostly undefined opcodes
		return w;
	endfunction

	function automatic logic [151:0] out_bundle();
		return {ex_valid, ex_control, ex_alu_op, ex_rs_val, ex_rt_val, ex_imm, ex_dst,
			ex_branch_taken, ex_target};
	endfunction

	task automatic compare_value(input string what, input instr_t w, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			fail_count++;
			$display("MISMATCH at %0t: %s is %h, expected %h, instr %h", $time, what, got,
				want, w);
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_bundle(input txn_t e);
		logic [0:ctrl_width-1] ctrl;
		ctrl = model_control(e.instr);
		compare_value("ex_control", e.instr, ex_control, ctrl);
		compare_value("ex_alu_op", e.instr, ex_alu_op, model_alu(e.instr));
		compare_value("ex_rs_val", e.instr, ex_rs_val, e.rs_val);
		compare_value("ex_rt_val", e.instr, ex_rt_val, e.rt_val);
		compare_value("ex_imm", e.instr, ex_imm, model_imm(e.instr, ctrl));
		compare_value("ex_dst", e.instr, ex_dst, model_dst(e.instr, ctrl));
		compare_value("ex_branch_taken", e.instr, ex_branch_taken,
			model_taken(e.instr, ctrl, e.rs_val, e.rt_val));
		compare_value("ex_target", e.instr, ex_target,
			model_target(e.instr, ctrl, e.pc, e.rs_val));
	endtask

	// outputs and model state are stable mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (load_pending) begin
				if (ex_valid && (exp_q.size() == 0)) begin
					fail_count++;
					$display("output at %0t with no instruction outstanding", $time);
				end else if (ex_valid) begin
					head = exp_q.pop_front();
					check_bundle(head);
				end else if (exp_q.size() != 0) begin
					fail_count++;
					$display("instruction %h lost, no output at %0t", exp_q[0].instr, $time);
					exp_q.delete(0);
				end
			end else if (out_bundle() !== out_held) begin
				fail_count++;
				$display("MISMATCH at %0t: outputs changed during stall", $time);
			end
			out_held = out_bundle();
			load_pending = !stall;
			if (!stall) begin
				// held instruction reads now and moves out at the next edge
				if (m_in_valid) begin
					entry.instr = m_in_instr;
					entry.pc = m_in_pc;
					entry.rs_val = shadow_read(m_in_instr.r.rs);
					entry.rt_val = shadow_read(m_in_instr.r.rt);
					exp_q.push_back(entry);
				end
				m_in_valid = instr_valid;
				m_in_instr = instr;
				m_in_pc = pc_plus4;
			end
			if (wb_en && (wb_addr != 5'd0)) begin
				shadow[wb_addr] = wb_data;
			end
		end
	end

	always @(posedge clk) begin
		edge_no++;
		if (edge_no > cycle_limit) begin
			$display("timeout, run went past %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic drive_writeback(input int mode);
		wb_en <= (pick(2) == 0);
		wb_data <= pick_value();
		// aim at the operand read in the coming cycle
		if (pick(4) == 0) begin
			wb_addr <= instr.r.rs;
		end else if (mode == 3) begin
			wb_addr <= pick(8);
		end else begin
			wb_addr <= pick(32);
		end
	endtask

	// n accepted instructions, pins held while stalled
	task automatic run_random(input int n, input int mode, input bit use_stall);
		int accepted;
		int burst;
		accepted = 0;
		burst = 0;
		while (accepted < n) begin
			@(posedge clk);
			if (instr_valid && !stall) begin
				accepted++;
			end
			if (!stall) begin
				instr_valid <= (accepted < n) && (pick(100) < 85);
				instr <= make_instr(mode);
				pc_plus4 <= $random(seed) & 32'hffff_fffc;
			end
			if (burst > 0) begin
				stall <= 1'b1;
				burst--;
			end else if (use_stall && (pick(100) < 15)) begin
				stall <= 1'b1;
				burst = pick(4);
			end else begin
				stall <= 1'b0;
			end
			drive_writeback(mode);
		end
	endtask

	task automatic drain();
		@(posedge clk);
		stall <= 1'b0;
		instr_valid <= 1'b0;
		wb_en <= 1'b0;
		while (m_in_valid || (exp_q.size() != 0)) begin
			@(posedge clk);
		end
	endtask

	task automatic run_test(input string name, input int n, input int mode, input bit use_stall);
		int start;
		start = fail_count;
		run_random(n, mode, use_stall);
		drain();
		$display("%s: %0d instructions, %0d errors", name, n, fail_count - start);
	endtask

	task automatic reset_and_regs();
		int start;
		start = fail_count;
		@(negedge clk);
		if (out_bundle() !== '0) begin
			fail_count++;
			$display("MISMATCH at %0t: outputs not idle after reset", $time);
		end else begin
			pass_count++;
		end
		// fill every register, r0 included
		for (int i = 0; i < 32; i++) begin
			@(posedge clk);
			wb_en <= 1'b1;
			wb_addr <= i;
			wb_data <= pick_value();
		end
		run_random(64, 1, 1'b0);
		drain();
		$display("test 1 reset and register file: %0d errors", fail_count - start);
	endtask

	initial begin
		seed = 32'h82d80297;
		clk = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc_plus4 = 32'd0;
		wb_en = 1'b0;
		wb_addr = 5'd0;
		wb_data = 32'd0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		reset_and_regs();
		run_test("test 2 control word", 400, 0, 1'b0);
		run_test("test 3 alu operation", 150, 1, 1'b0);
		run_test("test 4 immediate", 150, 2, 1'b0);
		run_test("test 5 branches and jumps", 200, 3, 1'b0);
		run_test("test 6 latency and stall", 200, 0, 1'b1);
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            stall,
	input  logic                            instr_valid,
	input  mips_pkg::instr_t                instr,
	input  logic [31:0]                     pc_plus4,
	input  logic                            wb_en,
	input  logic [4:0]                      wb_addr,
	input  logic [31:0]                     wb_data,
	output logic                            ex_valid,
	output logic [0:mips_pkg::ctrl_width-1] ex_control,
	output logic [3:0]                      ex_alu_op,
	output logic [31:0]                     ex_rs_val,
	output logic [31:0]                     ex_rt_val,
	output logic [31:0]                     ex_imm,
	output logic [4:0]                      ex_dst,
	output logic                            ex_branch_taken,
	output logic [31:0]                     ex_target
);
	import mips_pkg::*;

	// input register
	logic                  in_valid;
	instr_t                in_instr;
	logic [31:0]           in_pc_plus4;
	// decode datapath
	logic [0:ctrl_width-1] control;
	logic [3:0]            alu_op;
	logic [31:0]           rs_val;
	logic [31:0]           rt_val;
	logic                  zero_ext;
	logic [31:0]           imm_ext;
	logic [4:0]            dst;
	logic                  taken;
	logic [31:0]           dest;

	// fetch side, holds while stalled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid    <= 1'b0;
			in_instr    <= '0;
			in_pc_plus4 <= 32'd0;
		end else if (!stall) begin
			in_valid    <= instr_valid;
			in_instr    <= instr;
			in_pc_plus4 <= pc_plus4;
		end
	end

	main_decoder u_main_decoder (
		.op      (in_instr.r.op),
		.rs      (in_instr.r.rs),
		.rt      (in_instr.r.rt),
		.funct   (in_instr.r.funct),
		.control (control)
	);

	alu_decoder u_alu_decoder (
		.op     (in_instr.r.op),
		.funct  (in_instr.r.funct),
		.alu_op (alu_op)
	);

	// writeback lands here, reads happen between the two edges
	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (in_instr.r.rs),
		.rd_addr_b (in_instr.r.rt),
		.wr_en     (wb_en),
		.wr_addr   (wb_addr),
		.wr_data   (wb_data),
		.rd_data_a (rs_val),
		.rd_data_b (rt_val)
	);

	branch_resolver u_branch_resolver (
		.op       (in_instr.r.op),
		.rt       (in_instr.r.rt),
		.funct    (in_instr.r.funct),
		.branch   (control[ctl_branch]),
		.jump     (control[ctl_jump]),
		.pc_plus4 (in_pc_plus4),
		.rs_val   (rs_val),
		.rt_val   (rt_val),
		.imm      (in_instr.i.imm),
		.target   (in_instr.j.target),
		.taken    (taken),
		.dest     (dest)
	);

	// logical immediates are unsigned
	assign zero_ext = (in_instr.i.op == op_andi) || (in_instr.i.op == op_ori) ||
		(in_instr.i.op == op_xori);

	always_comb begin
		if (control[ctl_upper_imm]) begin
			imm_ext = {in_instr.i.imm, 16'h0000};
		end else if (zero_ext) begin
			imm_ext = {16'h0000, in_instr.i.imm};
		end else begin
			imm_ext = {{16{in_instr.i.imm[15]}}, in_instr.i.imm};
		end
	end

	// destination by reg_dst
	always_comb begin
		case (control[ctl_reg_dst +: 2])
			2'b01: begin
				dst = in_instr.r.rd;
			end
			// link register
			2'b10: begin
				dst = 5'd31;
			end
			default: begin
				dst = in_instr.r.rt;
			end
		endcase
	end

	// execute side, same stall as the input register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid        <= 1'b0;
			ex_control      <= '0;
			ex_alu_op       <= 4'd0;
			ex_rs_val       <= 32'd0;
			ex_rt_val       <= 32'd0;
			ex_imm          <= 32'd0;
			ex_dst          <= 5'd0;
			ex_branch_taken <= 1'b0;
			ex_target       <= 32'd0;
		end else if (!stall) begin
			ex_valid        <= in_valid;
			ex_control      <= control;
			ex_alu_op       <= alu_op;
			ex_rs_val       <= rs_val;
			ex_rt_val       <= rt_val;
			ex_imm          <= imm_ext;
			ex_dst          <= dst;
			// bubbles never redirect fetch
			ex_branch_taken <= in_valid && taken;
			ex_target       <= dest;
		end
	end

	// taken only ever travels with a valid instruction
	assert property (@(posedge clk) disable iff (!rst_n) ex_branch_taken |-> ex_valid)
		else $error("decode_stage taken branch without valid");

endmodule

// File: hdl/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
	input  logic [5:0]  op,
	input  logic [4:0]  rt,
	input  logic [5:0]  funct,
	input  logic        branch,
	input  logic        jump,
	input  logic [31:0] pc_plus4,
	input  logic [31:0] rs_val,
	input  logic [31:0] rt_val,
	input  logic [15:0] imm,
	input  logic [25:0] target,
	output logic        taken,
	output logic [31:0] dest
);
	import mips_pkg::*;

	// branch condition met
	logic        cond;
	// jr or jalr, target comes from rs
	logic        jreg;
	logic [31:0] br_dest;
	logic [31:0] j_dest;

	// pc-relative, word offset
	assign br_dest = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
	// pseudo-direct, stays in the current 256 MB region
	assign j_dest = {pc_plus4[31:28], target, 2'b00};
	assign jreg = (op == op_r_type) && ((funct == fn_jr) || (funct == fn_jalr));

	always_comb begin
		case (op)
			op_beq: begin
				cond = (rs_val == rt_val);
			end
			op_bne: begin
				cond = (rs_val != rt_val);
			end
			// signed compares against zero
			op_blez: begin
				cond = rs_val[31] || (rs_val == 32'd0);
			end
			op_bgtz: begin
				cond = !rs_val[31] && (rs_val != 32'd0);
			end
			// regimm, link forms compare the same way
			op_branchs: begin
				case (rt)
					rt_bltz, rt_bltzal: begin
						cond = rs_val[31];
					end
					rt_bgez, rt_bgezal: begin
						cond = !rs_val[31];
					end
					default: begin
						cond = 1'b0;
					end
				endcase
			end
			default: begin
				cond = 1'b0;
			end
		endcase
	end

	// jumps are unconditional
	assign taken = jump || (branch && cond);
	assign dest = jump ? (jreg ? rs_val : j_dest) : br_dest;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rd_addr_a,
	input  logic [4:0]  rd_addr_b,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data_a,
	output logic [31:0] rd_data_b
);

	// r1..r31 only, r0 is a constant
	logic [31:0] regs [1:31];
	// write that actually lands
	logic        wr_live;

	assign wr_live = wr_en && (wr_addr != 5'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// one read port, with same-cycle write bypass
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return 32'd0;
		end else if (wr_live && (addr == wr_addr)) begin
			return wr_data;
		end else begin
			return regs[addr];
		end
	endfunction

	always_comb begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
	end

	// r0 reads zero even while a write to r0 is on the port
	assert property (@(posedge clk) disable iff (!rst_n)
		((rd_addr_a != 5'd0) || (rd_data_a == 32'd0)) &&
		((rd_addr_b != 5'd0) || (rd_data_b == 32'd0)))
		else $error("reg_file register zero read nonzero");

endmodule

// File: hdl/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
	input  logic [5:0] op,
	input  logic [5:0] funct,
	output logic [3:0] alu_op
);
	import mips_pkg::*;

	// r-type funct to alu op
	function automatic logic [3:0] r_type_op(input logic [5:0] fn);
		case (fn)
			fn_add:  return alu_add;
			fn_addu: return alu_addu;
			fn_sub:  return alu_sub;
			fn_subu: return alu_subu;
			fn_and:  return alu_and;
			fn_or:   return alu_or;
			fn_xor:  return alu_xor;
			fn_nor:  return alu_nor;
			fn_slt:  return alu_slt;
			fn_sltu: return alu_sltu;
			// fixed and variable shifts share a unit
			fn_sll, fn_sllv: begin
				return alu_sll;
			end
			fn_srl, fn_srlv: begin
				return alu_srl;
			end
			fn_sra, fn_srav: begin
				return alu_sra;
			end
			// jr, jalr, hi/lo, mult and div skip the alu
			default: begin
				return alu_nop;
			end
		endcase
	endfunction

	always_comb begin
		case (op)
			op_r_type: begin
				alu_op = r_type_op(funct);
			end
			// immediate forms follow their register twins
			op_addi: begin
				alu_op = alu_add;
			end
			op_addiu: begin
				alu_op = alu_addu;
			end
			op_slti: begin
				alu_op = alu_slt;
			end
			op_sltiu: begin
				alu_op = alu_sltu;
			end
			op_andi: begin
				alu_op = alu_and;
			end
			op_ori: begin
				alu_op = alu_or;
			end
			op_xori: begin
				alu_op = alu_xor;
			end
			op_lui: begin
				alu_op = alu_lui;
			end
			// effective address, base plus offset
			op_lw, op_lb, op_lbu, op_lh, op_lhu, op_sw, op_sb, op_sh: begin
				alu_op = alu_addu;
			end
			// branches, jumps and cp0 moves
			default: begin
				alu_op = alu_nop;
			end
		endcase
	end

endmodule

// File: hdl/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
	input  logic [5:0]                      op,
	input  logic [4:0]                      rs,
	input  logic [4:0]                      rt,
	input  logic [5:0]                      funct,
	output logic [0:mips_pkg::ctrl_width-1] control
);
	import mips_pkg::*;

	// field order of every literal below
	// reg_write _ reg_dst _ alu_src_pc _ alu_src_imm _ write_src _
	// hilo_read _ hilo_write _ branch _ upper_imm _ jump _ cp0_write
	always_comb begin
		case (op)
			op_r_type: begin
				case (funct)
					// hi/lo moves
					fn_mthi, fn_mtlo: begin
						control = 13'b0_00_0_0_00_1_1_0_0_0_0;
					end
					fn_mfhi, fn_mflo: begin
						control = 13'b1_01_0_0_00_1_0_0_0_0_0;
					end
					// multiply and divide write hi/lo
					fn_mult, fn_multu, fn_div, fn_divu: begin
						control = 13'b1_01_0_0_00_0_1_0_0_0_0;
					end
					// register jumps
					fn_jr: begin
						control = 13'b0_00_0_0_00_0_0_0_0_1_0;
					end
					// link into rd, pc feeds the alu
					fn_jalr: begin
						control = 13'b1_01_1_0_00_0_0_0_0_1_0;
					end
					// plain register-register alu ops
					default: begin
						control = 13'b1_01_0_0_00_0_0_0_0_0_0;
					end
				endcase
			end
			// immediate arithmetic and logic
			op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
				control = 13'b1_00_0_1_00_0_0_0_0_0_0;
			end
			// load upper sets the upper_imm bit
			op_lui: begin
				control = 13'b1_00_0_1_00_0_0_0_1_0_0;
			end
			// loads write back from memory
			op_lw, op_lb, op_lbu, op_lh, op_lhu: begin
				control = 13'b1_00_0_1_01_0_0_0_0_0_0;
			end
			// stores only need the address add
			op_sw, op_sb, op_sh: begin
				control = 13'b0_00_0_1_00_0_0_0_0_0_0;
			end
			// two-operand and compare-to-zero branches
			op_beq, op_bne, op_blez, op_bgtz: begin
				control = 13'b0_00_0_0_00_0_0_1_0_0_0;
			end
			// regimm group, sub-decoded by rt
			op_branchs: begin
				case (rt)
					// and-link forms write r31
					rt_bltzal, rt_bgezal: begin
						control = 13'b1_10_1_0_00_0_0_1_0_0_0;
					end
					// bltz, bgez and any unknown rt are plain branches
					default: begin
						control = 13'b0_00_0_0_00_0_0_1_0_0_0;
					end
				endcase
			end
			op_j: begin
				control = 13'b0_00_0_0_00_0_0_0_0_1_0;
			end
			op_jal: begin
				control = 13'b1_10_1_0_00_0_0_0_0_1_0;
			end
			// coprocessor 0 moves, sub-decoded by rs
			op_cop0: begin
				case (rs)
					rs_mfc: begin
						control = 13'b0_00_0_0_10_0_0_0_0_0_0;
					end
					rs_mtc: begin
						control = 13'b0_00_0_0_00_0_0_0_0_0_1;
					end
					default: begin
						control = '0;
					end
				endcase
			end
			// undefined opcode
			default: begin
				control = '0;
			end
		endcase
	end

	// reg_dst 11 has no destination, so no entry may write with it
	assert final (!(control[ctl_reg_write] && (control[ctl_reg_dst +: 2] == 2'b11)))
		else $error("main_decoder writes with reg_dst 11, op %b", op);

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] op_r_type  = 6'b000000;
	localparam logic [5:0] op_branchs = 6'b000001;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_jal     = 6'b000011;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_blez    = 6'b000110;
	localparam logic [5:0] op_bgtz    = 6'b000111;
	localparam logic [5:0] op_addi    = 6'b001000;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_sltiu   = 6'b001011;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;
	localparam logic [5:0] op_cop0    = 6'b010000;
	// loads
	localparam logic [5:0] op_lb      = 6'b100000;
	localparam logic [5:0] op_lh      = 6'b100001;
	localparam logic [5:0] op_lw      = 6'b100011;
	localparam logic [5:0] op_lbu     = 6'b100100;
	localparam logic [5:0] op_lhu     = 6'b100101;
	// stores
	localparam logic [5:0] op_sb      = 6'b101000;
	localparam logic [5:0] op_sh      = 6'b101001;
	localparam logic [5:0] op_sw      = 6'b101011;

	// funct field under op_r_type
	localparam logic [5:0] fn_sll   = 6'b000000;
	localparam logic [5:0] fn_srl   = 6'b000010;
	localparam logic [5:0] fn_sra   = 6'b000011;
	localparam logic [5:0] fn_sllv  = 6'b000100;
	localparam logic [5:0] fn_srlv  = 6'b000110;
	localparam logic [5:0] fn_srav  = 6'b000111;
	localparam logic [5:0] fn_jr    = 6'b001000;
	localparam logic [5:0] fn_jalr  = 6'b001001;
	localparam logic [5:0] fn_mfhi  = 6'b010000;
	localparam logic [5:0] fn_mthi  = 6'b010001;
	localparam logic [5:0] fn_mflo  = 6'b010010;
	localparam logic [5:0] fn_mtlo  = 6'b010011;
	localparam logic [5:0] fn_mult  = 6'b011000;
	localparam logic [5:0] fn_multu = 6'b011001;
	localparam logic [5:0] fn_div   = 6'b011010;
	localparam logic [5:0] fn_divu  = 6'b011011;
	localparam logic [5:0] fn_add   = 6'b100000;
	localparam logic [5:0] fn_addu  = 6'b100001;
	localparam logic [5:0] fn_sub   = 6'b100010;
	localparam logic [5:0] fn_subu  = 6'b100011;
	localparam logic [5:0] fn_and   = 6'b100100;
	localparam logic [5:0] fn_or    = 6'b100101;
	localparam logic [5:0] fn_xor   = 6'b100110;
	localparam logic [5:0] fn_nor   = 6'b100111;
	localparam logic [5:0] fn_slt   = 6'b101010;
	localparam logic [5:0] fn_sltu  = 6'b101011;

	// rt sub-codes under op_branchs
	localparam logic [4:0] rt_bltz   = 5'b00000;
	localparam logic [4:0] rt_bgez   = 5'b00001;
	localparam logic [4:0] rt_bltzal = 5'b10000;
	localparam logic [4:0] rt_bgezal = 5'b10001;

	// rs sub-codes under op_cop0
	localparam logic [4:0] rs_mfc = 5'b00000;
	localparam logic [4:0] rs_mtc = 5'b00100;

	// main control word, bit 0 is the leftmost
	localparam int ctrl_width      = 13;
	localparam int ctl_reg_write   = 0;
	// two bits wide, 00 rt / 01 rd / 10 r31
	localparam int ctl_reg_dst     = 1;
	localparam int ctl_alu_src_pc  = 3;
	localparam int ctl_alu_src_imm = 4;
	// two bits wide, 00 alu / 01 memory / 10 cp0
	localparam int ctl_write_src   = 5;
	localparam int ctl_hilo_read   = 7;
	localparam int ctl_hilo_write  = 8;
	localparam int ctl_branch      = 9;
	localparam int ctl_upper_imm   = 10;
	localparam int ctl_jump        = 11;
	localparam int ctl_cp0_write   = 12;

	// alu operation codes
	localparam logic [3:0] alu_add  = 4'd0;
	localparam logic [3:0] alu_addu = 4'd1;
	localparam logic [3:0] alu_sub  = 4'd2;
	localparam logic [3:0] alu_subu = 4'd3;
	localparam logic [3:0] alu_and  = 4'd4;
	localparam logic [3:0] alu_or   = 4'd5;
	localparam logic [3:0] alu_xor  = 4'd6;
	localparam logic [3:0] alu_nor  = 4'd7;
	localparam logic [3:0] alu_slt  = 4'd8;
	localparam logic [3:0] alu_sltu = 4'd9;
	localparam logic [3:0] alu_sll  = 4'd10;
	localparam logic [3:0] alu_srl  = 4'd11;
	localparam logic [3:0] alu_sra  = 4'd12;
	localparam logic [3:0] alu_lui  = 4'd13;
	localparam logic [3:0] alu_nop  = 4'd15;

	// one instruction word, three encodings
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target;
		} j;
	} instr_t;

endpackage
